// ==== execPkg.sv ====
package execPkg;

	////////////////////////////////////////////////////////////////////////////
	// Datapath types
	////////////////////////////////////////////////////////////////////////////

	typedef logic [31:0] word_t;     // Register and result word
	typedef logic [4:0]  aluCtrl_t;  // ALU operation code
	typedef logic [1:0]  resSel_t;   // Result source select
	typedef logic [4:0]  shamt_t;    // Shift or rotate amount

	// ALU operation codes in operation table order
	localparam aluCtrl_t aluAdd   = 5'd0;
	localparam aluCtrl_t aluSub   = 5'd1;
	localparam aluCtrl_t aluMult  = 5'd2;
	localparam aluCtrl_t aluAnd   = 5'd3;
	localparam aluCtrl_t aluOr    = 5'd4;
	localparam aluCtrl_t aluXor   = 5'd5;
	localparam aluCtrl_t aluNor   = 5'd6;
	localparam aluCtrl_t aluSll   = 5'd7;
	localparam aluCtrl_t aluSrl   = 5'd8;
	localparam aluCtrl_t aluRotr  = 5'd9;
	localparam aluCtrl_t aluSra   = 5'd10;
	localparam aluCtrl_t aluSeh   = 5'd11;
	localparam aluCtrl_t aluAddu  = 5'd12;
	localparam aluCtrl_t aluMultu = 5'd13;
	localparam aluCtrl_t aluSlt   = 5'd14;
	localparam aluCtrl_t aluSeb   = 5'd15;
	localparam aluCtrl_t aluSltu  = 5'd16;
	localparam aluCtrl_t aluSllv  = 5'd17;
	localparam aluCtrl_t aluSrlv  = 5'd18;
	localparam aluCtrl_t aluSrav  = 5'd19;
	localparam aluCtrl_t aluRotrv = 5'd20;
	localparam aluCtrl_t aluMove  = 5'd21;

	// Result mux sources
	localparam resSel_t resAlu = 2'd0;
	localparam resSel_t resHi  = 2'd1;
	localparam resSel_t resLo  = 2'd2;

	////////////////////////////////////////////////////////////////////////////
	// MIPS32 opcode and funct fields
	////////////////////////////////////////////////////////////////////////////

	localparam logic [5:0] opSpecial  = 6'h00;
	localparam logic [5:0] opAddi     = 6'h08;
	localparam logic [5:0] opAddiu    = 6'h09;
	localparam logic [5:0] opSlti     = 6'h0A;
	localparam logic [5:0] opSltiu    = 6'h0B;
	localparam logic [5:0] opAndi     = 6'h0C;
	localparam logic [5:0] opOri      = 6'h0D;
	localparam logic [5:0] opXori     = 6'h0E;
	localparam logic [5:0] opLui      = 6'h0F;
	localparam logic [5:0] opSpecial3 = 6'h1F;

	localparam logic [5:0] fnSll  = 6'h00;  // No rotate form
	localparam logic [5:0] fnSrl  = 6'h02;  // rotr when bit 21 set
	localparam logic [5:0] fnSra  = 6'h03;
	localparam logic [5:0] fnSllv = 6'h04;
	localparam logic [5:0] fnSrlv = 6'h06;  // rotrv when bit 6 set
	localparam logic [5:0] fnSrav = 6'h07;
	localparam logic [5:0] fnMfhi = 6'h10;
	localparam logic [5:0] fnMthi = 6'h11;
	localparam logic [5:0] fnMflo = 6'h12;
	localparam logic [5:0] fnMtlo = 6'h13;
	localparam logic [5:0] fnMult = 6'h18;
	localparam logic [5:0] fnMultu = 6'h19;
	localparam logic [5:0] fnAdd  = 6'h20;
	localparam logic [5:0] fnAddu = 6'h21;
	localparam logic [5:0] fnSub  = 6'h22;
	localparam logic [5:0] fnSubu = 6'h23;
	localparam logic [5:0] fnAnd  = 6'h24;
	localparam logic [5:0] fnOr   = 6'h25;
	localparam logic [5:0] fnXor  = 6'h26;
	localparam logic [5:0] fnNor  = 6'h27;
	localparam logic [5:0] fnSlt  = 6'h2A;
	localparam logic [5:0] fnSltu = 6'h2B;

	// SPECIAL3 BSHFL subcodes sit in the sa field
	localparam logic [5:0] fnBshfl = 6'h20;
	localparam shamt_t     saSeb   = 5'h10;
	localparam shamt_t     saSeh   = 5'h18;

endpackage

// ==== aluControl.sv ====
`timescale 1ns/1ps

module aluControl import execPkg::*; (
	input  word_t    instr,
	output aluCtrl_t aluCtrl,
	output logic     useImm,     // B from immediate field
	output logic     immSigned,  // Sign extend the immediate
	output logic     isLui,      // Force shift by 16
	output resSel_t  resSel,
	output logic     hiWrite,
	output logic     loWrite,
	output logic     fromMult,   // HI takes the product high word
	output logic     illegal
);

	logic [5:0] opcode;
	logic [5:0] funct;
	shamt_t     saField;

	assign opcode  = instr[31:26];
	assign funct   = instr[5:0];
	assign saField = instr[10:6];

	always_comb begin
		// Safe defaults, an R-type add with nothing written
		aluCtrl   = aluAdd;
		useImm    = 1'b0;
		immSigned = 1'b0;
		isLui     = 1'b0;
		resSel    = resAlu;
		hiWrite   = 1'b0;
		loWrite   = 1'b0;
		fromMult  = 1'b0;
		illegal   = 1'b0;

		case (opcode)
			opSpecial: begin
				case (funct)
					fnAdd:  aluCtrl = aluAdd;
					fnAddu: aluCtrl = aluAddu;
					fnSub:  aluCtrl = aluSub;
					fnSubu: aluCtrl = aluSub;   // No overflow trap, same result
					fnAnd:  aluCtrl = aluAnd;
					fnOr:   aluCtrl = aluOr;
					fnXor:  aluCtrl = aluXor;
					fnNor:  aluCtrl = aluNor;
					fnSlt:  aluCtrl = aluSlt;
					fnSltu: aluCtrl = aluSltu;
					fnSll:  aluCtrl = aluSll;
					fnSrl:  aluCtrl = instr[21] ? aluRotr : aluSrl;
					fnSra:  aluCtrl = aluSra;
					fnSllv: aluCtrl = aluSllv;
					fnSrlv: aluCtrl = instr[6] ? aluRotrv : aluSrlv;
					fnSrav: aluCtrl = aluSrav;
					fnMult, fnMultu: begin
						aluCtrl  = (funct == fnMult) ? aluMult : aluMultu;
						hiWrite  = 1'b1;
						loWrite  = 1'b1;
						fromMult = 1'b1;
					end
					fnMfhi: resSel = resHi;
					fnMflo: resSel = resLo;
					fnMthi: begin
						aluCtrl = aluMove;  // rs passes straight through
						hiWrite = 1'b1;
					end
					fnMtlo: begin
						aluCtrl = aluMove;
						loWrite = 1'b1;
					end
					default: illegal = 1'b1;
				endcase
			end
			opAddi:  {aluCtrl, useImm, immSigned} = {aluAdd, 1'b1, 1'b1};
			opAddiu: {aluCtrl, useImm, immSigned} = {aluAddu, 1'b1, 1'b1};
			opSlti:  {aluCtrl, useImm, immSigned} = {aluSlt, 1'b1, 1'b1};
			opSltiu: {aluCtrl, useImm, immSigned} = {aluSltu, 1'b1, 1'b1}; // MIPS sign extends
			opAndi:  {aluCtrl, useImm} = {aluAnd, 1'b1};
			opOri:   {aluCtrl, useImm} = {aluOr, 1'b1};
			opXori:  {aluCtrl, useImm} = {aluXor, 1'b1};
			opLui: begin
				// imm << 16 through the shifter
				aluCtrl = aluSll;
				useImm  = 1'b1;
				isLui   = 1'b1;
			end
			opSpecial3: begin
				if (funct == fnBshfl && saField == saSeb)
					aluCtrl = aluSeb;
				else if (funct == fnBshfl && saField == saSeh)
					aluCtrl = aluSeh;
				else
					illegal = 1'b1;
			end
			default: illegal = 1'b1;
		endcase
	end

endmodule

// ==== alu32Bit.sv ====
`timescale 1ns/1ps

module alu32Bit import execPkg::*; #(
	parameter int dataWidth = 32
) (
	input  aluCtrl_t aluCtrl,
	input  word_t    a,
	input  word_t    b,
	input  shamt_t   shiftAmount,
	output word_t    aluResult,
	output word_t    hiResult,    // Upper product word
	output logic     zero
);

	logic signed [2*dataWidth-1:0] sProd;
	logic        [2*dataWidth-1:0] uProd;
	shamt_t                        varAmt;
	logic                          sLess;
	logic                          uLess;

	// Rotate right, zero amount returns the word as is
	function automatic word_t rotateRight(input word_t value, input shamt_t amt);
		word_t rotated;
		if (amt == '0)
			rotated = value;
		else
			rotated = (value >> amt) | (value << (dataWidth - amt));
		return rotated;
	endfunction

	assign sProd  = $signed(a) * $signed(b);
	assign uProd  = a * b;
	assign varAmt = a[4:0];                  // Variable shifts use rs low bits
	assign sLess  = $signed(a) < $signed(b);
	assign uLess  = a < b;

	///////////////////////////////////////////////////////////////////////////
	// Operation table
	///////////////////////////////////////////////////////////////////////////

	always_comb begin
		case (aluCtrl)
			aluAdd:   aluResult = a + b;
			aluSub:   aluResult = a - b;
			aluMult:  aluResult = sProd[dataWidth-1:0];
			aluAnd:   aluResult = a & b;
			aluOr:    aluResult = a | b;
			aluXor:   aluResult = a ^ b;
			aluNor:   aluResult = ~(a | b);
			aluSll:   aluResult = b << shiftAmount;
			aluSrl:   aluResult = b >> shiftAmount;
			aluRotr:  aluResult = rotateRight(b, shiftAmount);
			aluSra:   aluResult = $signed(b) >>> shiftAmount;
			aluSeh:   aluResult = {{(dataWidth-16){b[15]}}, b[15:0]};
			aluAddu:  aluResult = a + b;
			aluMultu: aluResult = uProd[dataWidth-1:0];
			aluSlt:   aluResult = {{(dataWidth-1){1'b0}}, sLess};
			aluSeb:   aluResult = {{(dataWidth-8){b[7]}}, b[7:0]};
			aluSltu:  aluResult = {{(dataWidth-1){1'b0}}, uLess};
			aluSllv:  aluResult = b << varAmt;
			aluSrlv:  aluResult = b >> varAmt;
			aluSrav:  aluResult = $signed(b) >>> varAmt;
			aluRotrv: aluResult = rotateRight(b, varAmt);
			aluMove:  aluResult = a;            // mthi, mtlo
			default:  aluResult = word_t'(1);   // Undefined code gives one
		endcase
	end

	// High word, only consumed on multiply
	always_comb begin
		if (aluCtrl == aluMultu)
			hiResult = uProd[2*dataWidth-1:dataWidth];
		else
			hiResult = sProd[2*dataWidth-1:dataWidth];
	end

	assign zero = (aluResult == '0);

endmodule

// ==== hiLoRegister.sv ====
`timescale 1ns/1ps

module hiLoRegister import execPkg::*; #(
	parameter int dataWidth = 32
) (
	input  logic  Clk,
	input  logic  arstN,
	input  logic  enable,      // Instruction valid this cycle
	input  logic  fromMult,
	input  logic  hiWrite,
	input  logic  loWrite,
	input  word_t aluResult,   // Product low word or moved rs
	input  word_t hiResult,    // Product high word
	output word_t hi,
	output word_t lo
);

	// HI register
	always_ff @(posedge Clk or negedge arstN) begin
		if (!arstN)
			hi <= {dataWidth{1'b0}};
		else if (enable && hiWrite)
			hi <= fromMult ? hiResult : aluResult;  // mult or mthi
	end

	// LO register, same source for mult and mtlo
	always_ff @(posedge Clk or negedge arstN) begin
		if (!arstN)
			lo <= {dataWidth{1'b0}};
		else if (enable && loWrite)
			lo <= aluResult;
	end

endmodule

// ==== executeStage.sv ====
`timescale 1ns/1ps

module executeStage import execPkg::*; #(
	parameter int dataWidth = 32
) (
	input  logic  Clk,
	input  logic  arstN,
	input  logic  inValid,
	input  word_t instr,
	input  word_t rsData,
	input  word_t rtData,
	output logic  outValid,
	output word_t outResult,
	output logic  outZero,
	output logic  outIllegal
);

	aluCtrl_t aluCtrl;
	resSel_t  resSel;
	logic     useImm;
	logic     immSigned;
	logic     isLui;
	logic     hiWrite;
	logic     loWrite;
	logic     fromMult;
	logic     illegal;

	word_t    immExt;
	word_t    opB;
	shamt_t   shiftAmount;
	word_t    aluResult;
	word_t    hiResult;
	logic     zero;
	word_t    hi;
	word_t    lo;
	word_t    resultMux;

	///////////////////////////////////////////////////////////////////////////
	// Decode and operands
	///////////////////////////////////////////////////////////////////////////

	aluControl u_aluControl (
		.instr     (instr),
		.aluCtrl   (aluCtrl),
		.useImm    (useImm),
		.immSigned (immSigned),
		.isLui     (isLui),
		.resSel    (resSel),
		.hiWrite   (hiWrite),
		.loWrite   (loWrite),
		.fromMult  (fromMult),
		.illegal   (illegal)
	);

	assign immExt = {{(dataWidth-16){immSigned & instr[15]}}, instr[15:0]};
	assign opB    = useImm ? immExt : rtData;
	assign shiftAmount = isLui ? shamt_t'(16) : instr[10:6];  // lui is imm << 16

	///////////////////////////////////////////////////////////////////////////
	// ALU and HI/LO
	///////////////////////////////////////////////////////////////////////////

	alu32Bit #(.dataWidth(dataWidth)) u_alu32Bit (
		.aluCtrl     (aluCtrl),
		.a           (rsData),
		.b           (opB),
		.shiftAmount (shiftAmount),
		.aluResult   (aluResult),
		.hiResult    (hiResult),
		.zero        (zero)
	);

	hiLoRegister #(.dataWidth(dataWidth)) u_hiLoRegister (
		.Clk       (Clk),
		.arstN     (arstN),
		.enable    (inValid),
		.fromMult  (fromMult),
		.hiWrite   (hiWrite),
		.loWrite   (loWrite),
		.aluResult (aluResult),
		.hiResult  (hiResult),
		.hi        (hi),
		.lo        (lo)
	);

	// mfhi and mflo read the already updated registers
	always_comb begin
		case (resSel)
			resHi:   resultMux = hi;
			resLo:   resultMux = lo;
			default: resultMux = aluResult;
		endcase
	end

	///////////////////////////////////////////////////////////////////////////
	// One cycle output register
	///////////////////////////////////////////////////////////////////////////

	always_ff @(posedge Clk or negedge arstN) begin
		if (!arstN) begin
			outValid   <= 1'b0;
			outResult  <= {dataWidth{1'b0}};
			outZero    <= 1'b0;
			outIllegal <= 1'b0;
		end else begin
			outValid <= inValid;
			if (inValid) begin  // Hold last data while idle
				outResult  <= resultMux;
				outZero    <= zero;
				outIllegal <= illegal;
			end
		end
	end

endmodule

// ==== tbExecuteStage.sv ====
`timescale 1ns/1ps

module tbExecuteStage import execPkg::*; ();

	localparam int maxCycles = 2000;  // Tests take a few hundred cycles

	logic  Clk;
	logic  arstN;
	logic  inValid;
	word_t instr;
	word_t rsData;
	word_t rtData;
	logic  outValid;
	word_t outResult;
	logic  outZero;
	logic  outIllegal;

	integer seed = 32'h1196_7c9d;
	int     errors = 0;
	int     checks = 0;
	int     testErrors = 0;
	int     cycles = 0;
	int     negCount = 0;
	string  curTest = "reset";
	word_t  modelHi;
	word_t  modelLo;

	// Pending responses as {chkRes, chkZero, illegal, result}
	logic [34:0] expQ[$];
	int          dueQ[$];  // Falling edge where the result must show

	executeStage #(.dataWidth(32)) u_executeStage (
		.Clk        (Clk),
		.arstN      (arstN),
		.inValid    (inValid),
		.instr      (instr),
		.rsData     (rsData),
		.rtData     (rtData),
		.outValid   (outValid),
		.outResult  (outResult),
		.outZero    (outZero),
		.outIllegal (outIllegal)
	);

	initial begin
		Clk = 1'b0;
		forever #5 Clk = ~Clk;
	end

	// Cycle limit for the whole run
	initial begin
		while (cycles < maxCycles) begin
			@(posedge Clk);
			cycles++;
		end
		$display("timeout: run stopped after %0d cycles", cycles);
		$display("TEST FAILED");
		$finish;
	end

	////////////////////////////////////////////////////////////////////////////
	// Encoders and reference model
	////////////////////////////////////////////////////////////////////////////

	function automatic word_t encodeR(input logic [5:0] funct, input logic [4:0] rsField,
		input logic [4:0] sa);
		return {6'h00, rsField, 5'd2, 5'd3, sa, funct};  // SPECIAL with rt 2 and rd 3
	endfunction

	function automatic word_t encodeI(input logic [5:0] op, input logic [15:0] imm);
		return {op, 5'd1, 5'd2, imm};
	endfunction

	function automatic word_t rotateWord(input word_t value, input logic [4:0] amt);
		logic [63:0] both;
		both = {value, value} >> amt;  // Low half is the rotated word
		return both[31:0];
	endfunction

	task automatic modelExec(input word_t ins, input word_t rs, input word_t rt,
		output word_t res, output bit chkRes, output bit chkZero, output bit ill);
		logic [5:0]  op;
		logic [5:0]  fn;
		logic [4:0]  sa;
		word_t       sImm;
		word_t       zImm;
		logic [63:0] prod;
		op   = ins[31:26];
		fn   = ins[5:0];
		sa   = ins[10:6];
		sImm = {{16{ins[15]}}, ins[15:0]};
		zImm = {16'h0000, ins[15:0]};
		res  = 32'd0;
		{ill, chkRes, chkZero} = 3'b011;
		case (op)
			6'h00: begin
				case (fn)
					6'h20, 6'h21: res = rs + rt;  // add, addu
					6'h22, 6'h23: res = rs - rt;  // sub, subu
					6'h24: res = rs & rt;
					6'h25: res = rs | rt;
					6'h26: res = rs ^ rt;
					6'h27: res = ~(rs | rt);
					6'h2A: res = {31'b0, $signed(rs) < $signed(rt)};
					6'h2B: res = {31'b0, rs < rt};
					6'h00: res = rt << sa;
					6'h02: res = ins[21] ? rotateWord(rt, sa) : rt >> sa;  // R bit picks rotr
					6'h03: res = $signed(rt) >>> sa;
					6'h04: res = rt << rs[4:0];
					6'h06: res = ins[6] ? rotateWord(rt, rs[4:0]) : rt >> rs[4:0];
					6'h07: res = $signed(rt) >>> rs[4:0];
					6'h18, 6'h19: begin
						if (fn == 6'h18)
							prod = $signed({{32{rs[31]}}, rs}) * $signed({{32{rt[31]}}, rt});
						else
							prod = {32'h0, rs} * {32'h0, rt};
						{modelHi, modelLo} = prod;
						{chkRes, chkZero} = 2'b00;  // No GPR result
					end
					6'h10: {res, chkZero} = {modelHi, 1'b0};  // mfhi
					6'h12: {res, chkZero} = {modelLo, 1'b0};  // mflo
					6'h11: {modelHi, chkRes, chkZero} = {rs, 2'b00};
					6'h13: {modelLo, chkRes, chkZero} = {rs, 2'b00};
					default: {ill, chkRes, chkZero} = 3'b100;
				endcase
			end
			6'h08, 6'h09: res = rs + sImm;
			6'h0A: res = {31'b0, $signed(rs) < $signed(sImm)};
			6'h0B: res = {31'b0, rs < sImm};  // Sign extended then compared unsigned
			6'h0C: res = rs & zImm;
			6'h0D: res = rs | zImm;
			6'h0E: res = rs ^ zImm;
			6'h0F: res = {ins[15:0], 16'h0000};
			6'h1F: begin
				if (fn == 6'h20 && sa == 5'h10)
					res = {{24{rt[7]}}, rt[7:0]};  // seb
				else if (fn == 6'h20 && sa == 5'h18)
					res = {{16{rt[15]}}, rt[15:0]};  // seh
				else
					{ill, chkRes, chkZero} = 3'b100;
			end
			default: {ill, chkRes, chkZero} = 3'b100;
		endcase
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Drive, check and response monitor
	////////////////////////////////////////////////////////////////////////////

	task automatic checkValue(input string what, input word_t expected, input word_t actual);
		checks++;
		if (expected !== actual) begin
			errors++;
			$display("mismatch %s %s: expected %h actual %h", curTest, what, expected, actual);
		end
	endtask

	task automatic issueInstr(input word_t ins, input word_t rs, input word_t rt);
		word_t res;
		bit    chkRes;
		bit    chkZero;
		bit    ill;
		modelExec(ins, rs, rt, res, chkRes, chkZero, ill);
		@(posedge Clk);
		inValid <= 1'b1;
		instr   <= ins;
		rsData  <= rs;
		rtData  <= rt;
		expQ.push_back({chkRes, chkZero, ill, res});
		dueQ.push_back(negCount + 2);  // Captured at the next rising edge
	endtask

	// Sample on the falling edge away from the drive edge
	always @(negedge Clk) begin
		int          due;
		logic [34:0] entry;
		negCount++;
		if (dueQ.size() > 0 && dueQ[0] <= negCount) begin
			due   = dueQ.pop_front();
			entry = expQ.pop_front();
			if (!outValid) begin
				errors++;
				$display("error in %s: no outValid for the result due at edge %0d",
					curTest, due);
			end else begin
				if (entry[34])
					checkValue("result", entry[31:0], outResult);
				if (entry[33])
					checkValue("zero", {31'b0, entry[31:0] == 32'd0}, {31'b0, outZero});
				checkValue("illegal", {31'b0, entry[32]}, {31'b0, outIllegal});
			end
		end else if (outValid) begin
			errors++;
			$display("error in %s: outValid high with no result due", curTest);
		end
	end

	task automatic startTest(input string name);
		curTest    = name;
		testErrors = errors;
	endtask

	task automatic finishTest();
		@(posedge Clk);
		inValid <= 1'b0;
		while (dueQ.size() > 0)
			@(negedge Clk);
		repeat (3) @(negedge Clk);  // Idle cycles flag any stray outValid
		$display("%s done, %0d errors", curTest, errors - testErrors);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Directed tests
	////////////////////////////////////////////////////////////////////////////

	task automatic resetLatency();
		startTest("resetLatency");
		checkValue("outValid after reset", 32'd0, {31'b0, outValid});
		checkValue("outResult after reset", 32'd0, outResult);
		issueInstr(encodeR(6'h20, 5'd0, 5'd0), 32'h0000_1234, 32'hFFFF_0001);
		finishTest();
	endtask

	task automatic arithLogic();
		logic [5:0] fns [10] = '{6'h20, 6'h21, 6'h22, 6'h23, 6'h24, 6'h25, 6'h26, 6'h27,
			6'h2A, 6'h2B};
		word_t a;
		startTest("arithLogic");
		for (int i = 0; i < 40; i++)
			issueInstr(encodeR(fns[i % 10], 5'd0, 5'd0), $random(seed), $random(seed));
		a = $random(seed);
		issueInstr(encodeR(6'h22, 5'd0, 5'd0), a, a);  // Equal operands set the zero flag
		finishTest();
	endtask

	task automatic shiftRotate();
		logic [4:0] amtTable [4] = '{5'd0, 5'd1, 5'd31, 5'd16};
		logic [4:0] amt;
		word_t      val;
		word_t      rs;
		startTest("shiftRotate");
		for (int a = 0; a < 5; a++) begin
			amt = (a < 4) ? amtTable[a] : 5'($random(seed));
			for (int v = 0; v < 2; v++) begin
				val = {v == 0, 31'($random(seed))};  // Negative first
				rs  = {27'($random(seed)), amt};     // Upper bits ignored by variable forms
				issueInstr(encodeR(6'h00, 5'd0, amt), rs, val);
				issueInstr(encodeR(6'h02, 5'd0, amt), rs, val);
				issueInstr(encodeR(6'h02, 5'd1, amt), rs, val);  // rotr
				issueInstr(encodeR(6'h03, 5'd0, amt), rs, val);
				issueInstr(encodeR(6'h04, 5'd0, 5'd0), rs, val);
				issueInstr(encodeR(6'h06, 5'd0, 5'd0), rs, val);
				issueInstr(encodeR(6'h06, 5'd0, 5'd1), rs, val);  // rotrv
				issueInstr(encodeR(6'h07, 5'd0, 5'd0), rs, val);
			end
		end
		finishTest();
	endtask

	task automatic immediateOps();
		logic [5:0]  immOps [8] = '{6'h08, 6'h09, 6'h0A, 6'h0B, 6'h0C, 6'h0D, 6'h0E, 6'h0F};
		logic [15:0] immTable [4] = '{16'hFFFF, 16'h8000, 16'h7FFF, 16'hFF80};
		word_t       sxTable [3] = '{32'h0000_0080, 32'hFFFF_807F, 32'h1234_7F7F};
		logic [15:0] imm;
		word_t       val;
		startTest("immediateOps");
		for (int i = 0; i < 5; i++) begin
			imm = (i < 4) ? immTable[i] : 16'($random(seed));
			for (int k = 0; k < 8; k++)
				issueInstr(encodeI(immOps[k], imm), $random(seed), $random(seed));
		end
		for (int i = 0; i < 4; i++) begin
			val = (i < 3) ? sxTable[i] : $random(seed);
			issueInstr({6'h1F, 10'd0, 5'd3, 5'h10, 6'h20}, 32'd0, val);  // seb
			issueInstr({6'h1F, 10'd0, 5'd3, 5'h18, 6'h20}, 32'd0, val);  // seh
		end
		finishTest();
	endtask

	task automatic hiLoAccess();
		word_t mulA [4] = '{32'h8000_0000, 32'hFFFF_FFFF, 32'h7FFF_FFFF, 32'h8000_0000};
		word_t mulB [4] = '{32'h8000_0000, 32'h7FFF_FFFF, 32'hFFFF_FFFF, 32'hFFFF_FFFF};
		word_t a;
		word_t b;
		startTest("hiLoAccess");
		for (int i = 0; i < 5; i++) begin
			a = (i < 4) ? mulA[i] : $random(seed);
			b = (i < 4) ? mulB[i] : $random(seed);
			issueInstr(encodeR(6'h18, 5'd0, 5'd0), a, b);  // mult
			issueInstr(encodeR(6'h10, 5'd0, 5'd0), 32'd0, 32'd0);
			issueInstr(encodeR(6'h12, 5'd0, 5'd0), 32'd0, 32'd0);
			issueInstr(encodeR(6'h19, 5'd0, 5'd0), a, b);  // multu
			issueInstr(encodeR(6'h10, 5'd0, 5'd0), 32'd0, 32'd0);
			issueInstr(encodeR(6'h12, 5'd0, 5'd0), 32'd0, 32'd0);
		end
		a = $random(seed);
		b = $random(seed);
		issueInstr(encodeR(6'h11, 5'd0, 5'd0), a, 32'd0);  // mthi leaves LO alone
		issueInstr(encodeR(6'h12, 5'd0, 5'd0), 32'd0, 32'd0);
		issueInstr(encodeR(6'h10, 5'd0, 5'd0), 32'd0, 32'd0);
		issueInstr(encodeR(6'h13, 5'd0, 5'd0), b, 32'd0);  // mtlo leaves HI alone
		issueInstr(encodeR(6'h10, 5'd0, 5'd0), 32'd0, 32'd0);
		issueInstr(encodeR(6'h12, 5'd0, 5'd0), 32'd0, 32'd0);
		finishTest();
	endtask

	task automatic illegalOp();
		startTest("illegalOp");
		issueInstr(encodeR(6'h11, 5'd0, 5'd0), $random(seed), 32'd0);  // Known HI
		issueInstr({6'h3F, 26'($random(seed))}, $random(seed), $random(seed));
		issueInstr({6'h23, 26'($random(seed))}, $random(seed), $random(seed));  // lw
		issueInstr(encodeR(6'h01, 5'd0, 5'd0), $random(seed), $random(seed));
		issueInstr({6'h1F, 10'd0, 5'd3, 5'h02, 6'h20}, 32'd0, $random(seed));  // wsbh
		issueInstr(encodeR(6'h10, 5'd0, 5'd0), 32'd0, 32'd0);
		issueInstr(encodeR(6'h12, 5'd0, 5'd0), 32'd0, 32'd0);
		finishTest();
	endtask

	initial begin
		arstN   = 1'b0;
		inValid = 1'b0;
		instr   = '0;
		rsData  = '0;
		rtData  = '0;
		modelHi = '0;
		modelLo = '0;
		repeat (5) @(posedge Clk);
		arstN <= 1'b1;
		resetLatency();
		arithLogic();
		shiftRotate();
		immediateOps();
		hiLoAccess();
		illegalOp();
		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

// ==== project.f ====
execPkg.sv
aluControl.sv
alu32Bit.sv
hiLoRegister.sv
executeStage.sv
tbExecuteStage.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the execute stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing -Wno-fatal -f project.f --top-module tbExecuteStage \
	-Mdir obj_dir -o simExec > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
	cat "$BUILD_LOG"
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/simExec > "$SIM_LOG" 2>&1
simStatus=$?
cat "$SIM_LOG"
if [ $simStatus -ne 0 ]; then
	echo "simulation exited with status $simStatus"
	exit 1
fi

if grep -q "TEST FAILED" "$SIM_LOG"; then
	exit 1
fi
if ! grep -q "TEST OK" "$SIM_LOG"; then
	echo "simulation ended without a result line"
	exit 1
fi
exit 0
